//--- project.f
design/tag_pkg.sv
design/tag_fifo.sv
design/tag_cache.sv
design/tag_memory.sv
design/tag_unit.sv
bench/tag_unit_assertions.sv
bench/tag_unit_tb.sv

//--- bench/tag_unit_tb.sv
`timescale 1ns/1ps

module tag_unit_tb;

	localparam int LINES      = 16;
	localparam int MEM_LINES  = 64;
	localparam int FIFO_DEPTH = 4;
	localparam int TABLE_LEN  = 24;
	localparam int LIMIT      = TABLE_LEN * 40;  // Cycle budget for the whole run
	localparam int WORDS      = 2 ** (tag_pkg::ADDR_W - 3);

	typedef struct packed {
		tag_pkg::tag_op_e           op;
		logic [tag_pkg::ADDR_W-1:0] adr;
		logic                       tagi;
		logic                       exp;   // Expected tag for reads
	} entry_t;

	// ==================================================
	// Stimulus table applied back to back
	// ==================================================
	localparam entry_t STIM [TABLE_LEN] = '{
		'{tag_pkg::op_read,      14'h0000, 1'b0, 1'b0},  // Untouched words read as zero
		'{tag_pkg::op_read,      14'h3ff8, 1'b0, 1'b0},
		'{tag_pkg::op_write_cap, 14'h0108, 1'b1, 1'b0},
		'{tag_pkg::op_read,      14'h0108, 1'b0, 1'b1},
		'{tag_pkg::op_read,      14'h0110, 1'b0, 1'b0},  // Neighbour in the same line
		'{tag_pkg::op_write,     14'h0108, 1'b0, 1'b0},  // Plain store clears the tag
		'{tag_pkg::op_read,      14'h0108, 1'b0, 1'b0},
		'{tag_pkg::op_write_cap, 14'h0220, 1'b1, 1'b0},
		'{tag_pkg::op_write_cap, 14'h1228, 1'b1, 1'b0},  // Same index evicts the modified line
		'{tag_pkg::op_read,      14'h1228, 1'b0, 1'b1},
		'{tag_pkg::op_read,      14'h0220, 1'b0, 1'b1},  // Refilled from the tag memory
		'{tag_pkg::op_read,      14'h2220, 1'b0, 1'b0},
		'{tag_pkg::op_read,      14'h1228, 1'b0, 1'b1},
		'{tag_pkg::op_write_cap, 14'h0228, 1'b0, 1'b0},
		'{tag_pkg::op_read,      14'h0228, 1'b0, 1'b0},
		'{tag_pkg::op_write_cap, 14'h3000, 1'b1, 1'b0},
		'{tag_pkg::op_read,      14'h3000, 1'b0, 1'b1},
		'{tag_pkg::op_read,      14'h0000, 1'b0, 1'b0},
		'{tag_pkg::op_read,      14'h3000, 1'b0, 1'b1},
		'{tag_pkg::op_write_cap, 14'h3ff8, 1'b1, 1'b0},
		'{tag_pkg::op_read,      14'h3ff8, 1'b0, 1'b1},
		'{tag_pkg::op_write,     14'h3ff8, 1'b0, 1'b0},
		'{tag_pkg::op_read,      14'h3ff8, 1'b0, 1'b0},
		'{tag_pkg::op_read,      14'h0220, 1'b0, 1'b1}
	};

	logic                       clk;
	logic                       rst;
	logic                       req_valid;
	logic                       req_ready;
	tag_pkg::tag_op_e           req_op;
	logic [tag_pkg::ADDR_W-1:0] req_adr;
	logic                       req_tagi;
	logic                       rsp_valid;
	logic                       rsp_ready;
	logic                       rsp_tag;

	logic        model [WORDS];  // One tag bit per 8-byte word
	logic        expected_q [$]; // Read results still owed by the DUT in issue order
	int          value_errors = 0;
	int          other_errors = 0;
	int          cycles;
	int unsigned seed;

	tag_unit #(.LINES(LINES), .MEM_LINES(MEM_LINES), .FIFO_DEPTH(FIFO_DEPTH)) uut (
		.clk(clk), .rst(rst),
		.req_valid(req_valid), .req_ready(req_ready),
		.req_op(req_op), .req_adr(req_adr), .req_tagi(req_tagi),
		.rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_tag(rsp_tag)
	);

	bind tag_cache tag_unit_assertions cache_checks (
		.clk(clk), .rst(rst), .req_ready(req_ready),
		.rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_tag(rsp_tag),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack)
	);

	always #2 clk = ~clk;

	// Holds one request up until the FIFO takes it and then applies it to the model
	task automatic send_request(input entry_t e, input int n);
		int word;
		word = e.adr[tag_pkg::ADDR_W-1:3];
		req_op    = e.op;
		req_adr   = e.adr;
		req_tagi  = e.tagi;
		req_valid = 1'b1;
		while (!req_ready)
			@(negedge clk);  // Ready seen here means a transfer at the next rising edge
		case (e.op)
			tag_pkg::op_read: begin
				if (model[word] !== e.exp) begin
					other_errors++;
					$display("Table entry %0d expects %0b but the model holds %0b",
						n, e.exp, model[word]);
				end
				expected_q.push_back(model[word]);
			end
			tag_pkg::op_write: model[word] = 1'b0;
			default:           model[word] = e.tagi;  // Capability store
		endcase
		@(negedge clk);
	endtask

	task automatic check_response();
		logic exp;
		if (expected_q.size() == 0) begin
			other_errors++;
			$display("Read response at %0t ns with no read outstanding", $time);
		end else begin
			exp = expected_q.pop_front();
			if (rsp_tag !== exp) begin
				value_errors++;
				$display("[FAIL] %0t ns rsp_tag expected %0b got %0b", $time, exp, rsp_tag);
			end
		end
	endtask

	task automatic report_and_finish();
		$display("Errors: %0d total, %0d value mismatches, %0d other",
			value_errors + other_errors, value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	endtask

	// Ready only one cycle in eight so the response FIFO fills and the cache stalls
	// The values held across the next rising edge decide the transfer
	always @(negedge clk) begin
		rsp_ready = ($urandom % 8) == 0;
		if (!rst && rsp_valid && rsp_ready)
			check_response();
	end

	initial begin
		seed = 63;
		void'($urandom(seed));
		clk       = 1'b0;
		rst       = 1'b1;
		req_valid = 1'b0;
		req_op    = tag_pkg::op_read;
		req_adr   = '0;
		req_tagi  = 1'b0;
		rsp_ready = 1'b0;
		for (int i = 0; i < WORDS; i++)
			model[i] = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < TABLE_LEN; i++)
			send_request(STIM[i], i);
		req_valid = 1'b0;
		while (expected_q.size() != 0)
			@(negedge clk);  // Drain the responses still in flight
		other_errors += uut.cache.cache_checks.failures;
		report_and_finish();
	end

	// Watchdog on the cycle count
	initial begin
		cycles = 0;
		while (cycles < LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		other_errors++;
		$display("Timed out after %0d cycles with %0d reads unanswered", cycles, expected_q.size());
		report_and_finish();
	end

endmodule

//--- bench/tag_unit_assertions.sv
`timescale 1ns/1ps

// Protocol checks on the cache's Wishbone master and its request and response handshakes
module tag_unit_assertions (
	input logic clk,
	input logic rst,
	input logic req_ready,
	input logic rsp_valid,
	input logic rsp_ready,
	input logic rsp_tag,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack
);

	int failures = 0;  // Number of assertion failures so far

	// ==================================================
	// Wishbone classic master
	// ==================================================
	stb_inside_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
		else begin
			failures++;
			$error("wb_stb is high outside a bus cycle");
		end

	// A bus cycle may only end once the slave has acked
	cyc_held_to_ack: assert property (@(posedge clk) disable iff (rst)
		wb_cyc && !wb_ack |=> wb_cyc)
		else begin
			failures++;
			$error("wb_cyc dropped before wb_ack");
		end

	// ==================================================
	// Request and response handshakes
	// ==================================================
	no_accept_in_miss: assert property (@(posedge clk) disable iff (rst) req_ready |-> !wb_cyc)
		else begin
			failures++;
			$error("Request accepted while a miss is on the bus");
		end

	rsp_held_to_take: assert property (@(posedge clk) disable iff (rst)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_tag))  // Data must not move either
		else begin
			failures++;
			$error("Response withdrawn or changed before it was taken");
		end

endmodule

//--- design/tag_unit.sv
`timescale 1ns/1ps

// Request FIFO feeding the tag cache, which fills the response FIFO
// The tag memory sits behind the cache on Wishbone
module tag_unit #(
	parameter int LINES      = 16,
	parameter int MEM_LINES  = 64,
	parameter int FIFO_DEPTH = 4
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       req_valid,
	output logic                       req_ready,
	input  tag_pkg::tag_op_e           req_op,
	input  logic [tag_pkg::ADDR_W-1:0] req_adr,
	input  logic                       req_tagi,
	output logic                       rsp_valid,
	input  logic                       rsp_ready,
	output logic                       rsp_tag
);

	localparam int MEM_W = $clog2(MEM_LINES);

	tag_pkg::tag_req_t req_in;      // Client fields packed for the FIFO
	tag_pkg::tag_req_t req_head;    // Oldest request waiting for the cache
	logic              head_valid;
	logic              head_ready;
	logic              crsp_valid;  // Cache side of the response FIFO
	logic              crsp_ready;
	logic              crsp_tag;

	// ==================================================
	// Wishbone between the cache and the tag memory
	// ==================================================
	logic                          wb_cyc;
	logic                          wb_stb;
	logic                          wb_we;
	logic [MEM_W-1:0]              wb_adr;
	logic [tag_pkg::LINE_BITS-1:0] wb_dat_w;
	logic [tag_pkg::LINE_BITS-1:0] wb_dat_r;
	logic                          wb_ack;

	assign req_in = '{op: req_op, adr: req_adr, tagi: req_tagi};

	tag_fifo #(.payload_t(tag_pkg::tag_req_t), .DEPTH(FIFO_DEPTH)) req_fifo (
		.clk(clk), .rst(rst),
		.in_valid(req_valid), .in_ready(req_ready), .in_data(req_in),
		.out_valid(head_valid), .out_ready(head_ready), .out_data(req_head)
	);

	tag_cache #(.LINES(LINES), .MEM_LINES(MEM_LINES)) cache (
		.clk(clk), .rst(rst),
		.req_valid(head_valid), .req_ready(head_ready), .req(req_head),
		.rsp_valid(crsp_valid), .rsp_ready(crsp_ready), .rsp_tag(crsp_tag),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
	);

	tag_fifo #(.payload_t(logic), .DEPTH(FIFO_DEPTH)) rsp_fifo (
		.clk(clk), .rst(rst),
		.in_valid(crsp_valid), .in_ready(crsp_ready), .in_data(crsp_tag),
		.out_valid(rsp_valid), .out_ready(rsp_ready), .out_data(rsp_tag)
	);

	tag_memory #(.MEM_LINES(MEM_LINES)) memory (
		.clk(clk), .rst(rst),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
	);

endmodule

//--- design/tag_memory.sv
`timescale 1ns/1ps

// Backing store for every tag line, a Wishbone classic slave
module tag_memory #(
	parameter int MEM_LINES = 64
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          wb_cyc,
	input  logic                          wb_stb,
	input  logic                          wb_we,
	input  logic [$clog2(MEM_LINES)-1:0]  wb_adr,
	input  logic [tag_pkg::LINE_BITS-1:0] wb_dat_w,
	output logic [tag_pkg::LINE_BITS-1:0] wb_dat_r,
	output logic                          wb_ack
);

	logic [tag_pkg::LINE_BITS-1:0] mem [MEM_LINES];
	logic                          strobe;   // New access with no ack outstanding

	// A held strobe sees the ack that is up and does not start a second access
	assign strobe = wb_cyc && wb_stb && !wb_ack;

	// ==================================================
	// Ack generation and line storage
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_ack <= 1'b0;
			for (int i = 0; i < MEM_LINES; i++)
				mem[i] <= '0;  // Every word starts untagged
		end else begin
			wb_ack <= strobe;  // One cycle after the strobe, high for exactly one cycle
			// Write data is taken on the edge where the master samples ack
			if (wb_cyc && wb_stb && wb_we && wb_ack)
				mem[wb_adr] <= wb_dat_w;
		end
	end

	// Read data is loaded with the ack so both appear together
	always_ff @(posedge clk) begin
		if (strobe)
			wb_dat_r <= mem[wb_adr];
	end

endmodule

//--- design/tag_cache.sv
`timescale 1ns/1ps

// Direct-mapped write-back tag cache with write allocate
// Misses write back a modified victim and then refill over Wishbone classic
module tag_cache #(
	parameter int LINES     = 16,
	parameter int MEM_LINES = 64
) (
	input  logic                          clk,
	input  logic                          rst,
	// Request stream from the request FIFO
	input  logic                          req_valid,
	output logic                          req_ready,
	input  tag_pkg::tag_req_t             req,
	// Read responses into the response FIFO
	output logic                          rsp_valid,
	input  logic                          rsp_ready,
	output logic                          rsp_tag,
	// Wishbone classic master
	output logic                          wb_cyc,
	output logic                          wb_stb,
	output logic                          wb_we,
	output logic [$clog2(MEM_LINES)-1:0]  wb_adr,
	output logic [tag_pkg::LINE_BITS-1:0] wb_dat_w,
	input  logic [tag_pkg::LINE_BITS-1:0] wb_dat_r,
	input  logic                          wb_ack
);

	localparam int OFS_W = 3;                            // Byte offset inside an 8-byte word
	localparam int SEL_W = $clog2(tag_pkg::LINE_BITS);   // Word select inside a line
	localparam int IDX_W = $clog2(LINES);
	localparam int MEM_W = $clog2(MEM_LINES);            // Line address into the tag memory
	localparam int TAG_W = MEM_W - IDX_W;

	typedef enum logic [1:0] {
		st_idle,
		st_wb,       // Victim line going back to memory
		st_fetch,    // Needed line coming in
		st_respond   // Hit completing, response or write one cycle after accept
	} state_e;

	state_e state;

	logic [tag_pkg::LINE_BITS-1:0] lines [LINES];  // Tag-line array
	logic [TAG_W-1:0]              tags  [LINES];  // Line tags
	logic [LINES-1:0]              valid;
	logic [LINES-1:0]              modified;

	// Fields of the request at the FIFO head
	logic [SEL_W-1:0] req_sel;
	logic [MEM_W-1:0] req_line;
	logic [IDX_W-1:0] req_idx;
	logic [TAG_W-1:0] req_tag;
	logic             hit;
	logic             victim_dirty;

	// Accepted request held for the respond state
	tag_pkg::tag_op_e hold_op;
	logic [IDX_W-1:0] hold_idx;
	logic [SEL_W-1:0] hold_sel;
	logic             hold_bit;   // Value a write stores

	logic do_accept;
	logic do_write;
	logic do_refill;
	logic start_wb;
	logic start_fetch;

	// ==================================================
	// Address split and lookup
	// ==================================================
	assign req_sel  = req.adr[OFS_W +: SEL_W];
	assign req_line = req.adr[OFS_W + SEL_W +: MEM_W];
	assign req_idx  = req_line[IDX_W-1:0];
	assign req_tag  = req_line[MEM_W-1 -: TAG_W];

	assign hit          = valid[req_idx] && (tags[req_idx] == req_tag);
	assign victim_dirty = valid[req_idx] && modified[req_idx];  // Only a valid line can be dirty

	// A request is taken only on a hit, so a miss leaves it parked at the FIFO head
	assign req_ready = (state == st_idle) && req_valid && hit;
	assign do_accept = req_ready;

	assign rsp_valid = (state == st_respond) && (hold_op == tag_pkg::op_read);
	assign do_write  = (state == st_respond) && (hold_op != tag_pkg::op_read);
	assign do_refill = (state == st_fetch) && wb_cyc && wb_ack;

	// Bus cycle launch points
	assign start_wb    = (state == st_idle) && req_valid && !hit && victim_dirty;
	assign start_fetch = ((state == st_idle) && req_valid && !hit && !victim_dirty)
		|| ((state == st_fetch) && !wb_cyc);  // Second cycle of a dirty miss

	// ==================================================
	// Control state
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= st_idle;
			valid    <= '0;
			modified <= '0;
			wb_cyc   <= 1'b0;
			wb_stb   <= 1'b0;
			wb_we    <= 1'b0;
		end else begin
			if (do_refill) begin
				valid[req_idx]    <= 1'b1;
				modified[req_idx] <= 1'b0;  // Fresh copy matches memory
			end
			if (do_write)
				modified[hold_idx] <= 1'b1;

			// Strobe stays up until ack and falls on the ack edge
			if (start_wb || start_fetch) begin
				wb_cyc <= 1'b1;
				wb_stb <= 1'b1;
				wb_we  <= start_wb;
			end else if (wb_cyc && wb_ack) begin
				wb_cyc <= 1'b0;
				wb_stb <= 1'b0;
				wb_we  <= 1'b0;
			end

			case (state)
				st_idle: begin
					if (req_valid) begin
						if (hit)
							state <= st_respond;
						else if (victim_dirty)
							state <= st_wb;
						else
							state <= st_fetch;
					end
				end
				st_wb: begin
					if (wb_cyc && wb_ack)
						state <= st_fetch;  // Refill is launched one cycle later
				end
				st_fetch: begin
					if (do_refill)
						state <= st_idle;  // The parked request now hits
				end
				st_respond: begin
					if (!rsp_valid || rsp_ready)
						state <= st_idle;  // A full response FIFO holds us here
				end
				default: state <= st_idle;
			endcase
		end
	end

	// ==================================================
	// Arrays and held payload
	// ==================================================
	always_ff @(posedge clk) begin
		if (do_accept) begin
			hold_op  <= req.op;
			hold_idx <= req_idx;
			hold_sel <= req_sel;
			hold_bit <= (req.op == tag_pkg::op_write_cap) ? req.tagi : 1'b0;
			rsp_tag  <= lines[req_idx][req_sel];  // Read result waits in the respond state
		end

		if (start_wb) begin
			wb_adr   <= {tags[req_idx], req_idx};  // Victim line address
			wb_dat_w <= lines[req_idx];
		end else if (start_fetch) begin
			wb_adr <= req_line;
		end

		if (do_refill) begin
			lines[req_idx] <= wb_dat_r;
			tags[req_idx]  <= req_tag;
		end else if (do_write) begin
			lines[hold_idx][hold_sel] <= hold_bit;  // Plain store clears and capability sets
		end
	end

endmodule

//--- design/tag_fifo.sv
`timescale 1ns/1ps

// Circular buffer with valid/ready on both sides
// The payload type is chosen by the instantiating module
module tag_fifo #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 4
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];  // Storage, written only on push
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;        // Number of items held
	logic             push;
	logic             pop;

	// Advance a pointer and wrap at the last slot
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign in_ready  = (count != CNT_W'(DEPTH));  // Full blocks the producer
	assign out_valid = (count != '0);
	assign out_data  = mem[rd_ptr];               // Head is visible right after the push edge

	assign push = in_valid && in_ready;
	assign pop  = out_valid && out_ready;

	// ==================================================
	// Pointers and occupancy
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			// Simultaneous push and pop leave the count alone
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_data;
	end

endmodule

//--- design/tag_pkg.sv
// ==================================================
// Shared widths, opcodes and the request payload
// ==================================================

package tag_pkg;

	// Byte address width seen by the client
	localparam int ADDR_W = 14;

	// Tag bits held in one cache line, one per 8-byte word
	localparam int LINE_BITS = 32;

	// Request kinds accepted by the cache
	typedef enum logic [1:0] {
		op_read,       // Return the tag bit of the addressed word
		op_write,      // Plain data store which clears the tag
		op_write_cap   // Capability store which sets the tag to tagi
	} tag_op_e;

	// Request word carried through the request FIFO
	typedef struct packed {
		tag_op_e             op;
		logic [ADDR_W-1:0]   adr;   // Byte address
		logic                tagi;  // Tag value for op_write_cap
	} tag_req_t;

	// ==================================================
	// The struct packs to 2 + ADDR_W + 1 bits
	// ==================================================

endpackage
